/* logic/classifier_pkg.sv */
// flow classifier shared definitions
// widths, table entry and request/result structs, FSM states and
// register addresses used across the classifier blocks

package classifier_pkg;

    localparam int KEY_NBITS      = 32;
    localparam int FID_NBITS      = 8;
    localparam int TIME_NBITS     = 16;
    localparam int REG_ADDR_NBITS = 2;
    localparam int REG_DATA_NBITS = 16;

    // aging time loaded at reset, in ticks
    localparam logic [TIME_NBITS-1:0] AGING_RESET = 16'd100;

    typedef struct packed {
        logic                  valid;
        logic [KEY_NBITS-1:0]  key;
        logic [FID_NBITS-1:0]  fid;
        logic [TIME_NBITS-1:0] etime;
    } flow_entry_t;

    typedef struct packed {
        logic [KEY_NBITS-1:0] key;
        logic [7:0]           tag;
    } lookup_req_t;

    typedef struct packed {
        logic [KEY_NBITS-1:0] key;
        logic [FID_NBITS-1:0] fid;
    } learn_req_t;

    typedef struct packed {
        logic [7:0]           tag;
        logic                 hit;
        logic [FID_NBITS-1:0] fid;
    } lookup_res_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP_READ,
        LOOKUP_CMP,
        LEARN_READ,
        LEARN_WRITE
    } lookup_state_e;

    typedef enum logic [REG_ADDR_NBITS-1:0] {
        REG_AGING  = 2'd0,
        REG_HITS   = 2'd1,
        REG_MISSES = 2'd2,
        REG_TIME   = 2'd3
    } reg_addr_e;

endpackage

/* logic/time_counter.sv */
// real-time counter
// a prescaler divides the clock into ticks and the time counter
// advances by one on every tick, wrapping at its full width

module time_counter
    import classifier_pkg::*;
#(
    parameter int TICK_CYCLES = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    output logic [TIME_NBITS-1:0] current_time
);

    localparam int PRE_NBITS = (TICK_CYCLES > 1) ? $clog2(TICK_CYCLES) : 1;

    logic [PRE_NBITS-1:0] prescale;
    logic                 tick;

    assign tick = (prescale == PRE_NBITS'(TICK_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            prescale     <= '0;
            current_time <= '0;
        end else begin
            if (tick) begin
                prescale     <= '0;
                current_time <= current_time + 1'b1;
            end else begin
                prescale <= prescale + 1'b1;
            end
        end
    end

endmodule

/* logic/flow_hash.sv */
// flow key hash
// folds the four key bytes into two independent bucket indexes,
// the second one rotating each byte by its position first

module flow_hash
    import classifier_pkg::*;
#(
    parameter int DEPTH_NBITS = 4
) (
    input  logic [KEY_NBITS-1:0]   key,
    output logic [DEPTH_NBITS-1:0] idx0,
    output logic [DEPTH_NBITS-1:0] idx1
);

    logic [7:0] fold0;
    logic [7:0] fold1;

    function automatic logic [7:0] rotl8(input logic [7:0] b, input int unsigned n);
        logic [15:0] dbl;
        dbl = {b, b} << n;
        return dbl[15:8];
    endfunction

    always_comb begin
        fold0 = '0;
        fold1 = '0;
        for (int i = 0; i < 4; i++) begin
            fold0 ^= key[8*i +: 8];
            fold1 ^= rotl8(key[8*i +: 8], i);
        end
    end

    assign idx0 = fold0[DEPTH_NBITS-1:0];
    assign idx1 = fold1[DEPTH_NBITS-1:0];

endmodule

/* logic/flow_table.sv */
// two-bank flow table
// each bank holds one flow entry per bucket; both banks are read
// together on rd and a single bank is written on wr

module flow_table
    import classifier_pkg::*;
#(
    parameter int DEPTH_NBITS = 4
) (
    input  logic                   clk,
    input  logic                   reset,

    input  logic                   rd,
    input  logic [DEPTH_NBITS-1:0] idx0,
    input  logic [DEPTH_NBITS-1:0] idx1,
    output flow_entry_t            entry0,
    output flow_entry_t            entry1,

    input  logic                   wr,
    input  logic                   wr_bank,
    input  logic [DEPTH_NBITS-1:0] wr_idx,
    input  flow_entry_t            wr_entry
);

    localparam int DEPTH = 1 << DEPTH_NBITS;

    flow_entry_t bank [2][DEPTH];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // only the valid bits are cleared, the rest of an entry is
    // meaningless until it is written
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int b = 0; b < 2; b++) begin
                for (int i = 0; i < DEPTH; i++) begin
                    bank[b][i].valid <= 1'b0;
                end
            end
        end else if (wr) begin
            bank[wr_bank][wr_idx] <= wr_entry;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // each bank is looked up at its own hash index
    always_ff @(posedge clk) begin
        if (rd) begin
            entry0 <= bank[0][idx0];
            entry1 <= bank[1][idx1];
        end
    end

    // the sequencer must never read and write in the same cycle
    a_no_rd_wr: assert property (
        @(posedge clk) disable iff (reset)
        !(rd && wr)
    );

endmodule

/* logic/lookup_fsm.sv */
// lookup and learn sequencer
// latches one request at a time, reads both table banks, then either
// matches the key against live entries to build a result or picks
// a bank and writes the learned flow with its expiry time

module lookup_fsm
    import classifier_pkg::*;
#(
    parameter int DEPTH_NBITS = 4
) (
    input  logic                   clk,
    input  logic                   reset,

    input  logic                   par_valid,
    input  lookup_req_t            par_req,
    input  logic                   learn_valid,
    input  learn_req_t             learn_req,

    input  logic [TIME_NBITS-1:0]  current_time,
    input  logic [TIME_NBITS-1:0]  aging_time,

    output logic                   rd,
    output logic [DEPTH_NBITS-1:0] idx0,
    output logic [DEPTH_NBITS-1:0] idx1,
    input  flow_entry_t            entry0,
    input  flow_entry_t            entry1,
    output logic                   wr,
    output logic                   wr_bank,
    output logic [DEPTH_NBITS-1:0] wr_idx,
    output flow_entry_t            wr_entry,

    output logic                   cla_valid,
    output lookup_res_t            cla_res,
    output logic                   hit_inc,
    output logic                   miss_inc
);

    lookup_state_e state;

    logic [KEY_NBITS-1:0] key_q;
    logic [7:0]           tag_q;
    logic [FID_NBITS-1:0] fid_q;

    logic live0;
    logic live1;
    logic match0;
    logic match1;

    flow_hash #(
        .DEPTH_NBITS(DEPTH_NBITS)
    ) u_flow_hash (
        .key (key_q),
        .idx0(idx0),
        .idx1(idx1)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // entry compare
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // an entry is live until current time reaches its expiry time
    assign live0  = entry0.valid && (current_time < entry0.etime);
    assign live1  = entry1.valid && (current_time < entry1.etime);
    assign match0 = live0 && (entry0.key == key_q);
    assign match1 = live1 && (entry1.key == key_q);

    assign rd = (state == LOOKUP_READ) || (state == LEARN_READ);
    assign wr = (state == LEARN_WRITE);

    // bank 0 is reused when free, expired or already ours
    assign wr_bank        = live0 && (entry0.key != key_q);
    assign wr_idx         = wr_bank ? idx1 : idx0;
    assign wr_entry.valid = 1'b1;
    assign wr_entry.key   = key_q;
    assign wr_entry.fid   = fid_q;
    assign wr_entry.etime = current_time + aging_time;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sequencing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            cla_valid <= 1'b0;
            hit_inc   <= 1'b0;
            miss_inc  <= 1'b0;
        end else begin
            cla_valid <= 1'b0;
            hit_inc   <= 1'b0;
            miss_inc  <= 1'b0;
            case (state)
                IDLE: begin
                    if (par_valid) begin
                        state <= LOOKUP_READ;
                    end else if (learn_valid) begin
                        state <= LEARN_READ;
                    end
                end
                LOOKUP_READ: state <= LOOKUP_CMP;
                LOOKUP_CMP: begin
                    cla_valid <= 1'b1;
                    hit_inc   <= match0 || match1;
                    miss_inc  <= !(match0 || match1);
                    state     <= IDLE;
                end
                LEARN_READ:  state <= LEARN_WRITE;
                LEARN_WRITE: state <= IDLE;
                default:     state <= IDLE;
            endcase
        end
    end

    // request and result payload
    always_ff @(posedge clk) begin
        if (state == IDLE && par_valid) begin
            key_q <= par_req.key;
            tag_q <= par_req.tag;
        end else if (state == IDLE && learn_valid) begin
            key_q <= learn_req.key;
            fid_q <= learn_req.fid;
        end
        if (state == LOOKUP_CMP) begin
            cla_res.tag <= tag_q;
            cla_res.hit <= match0 || match1;
            cla_res.fid <= match0 ? entry0.fid : (match1 ? entry1.fid : '0);
        end
    end

    a_strobe_in_idle: assert property (
        @(posedge clk) disable iff (reset)
        (par_valid || learn_valid) |-> (state == IDLE)
    );

    a_one_strobe: assert property (
        @(posedge clk) disable iff (reset)
        !(par_valid && learn_valid)
    );

    a_result_after_cmp: assert property (
        @(posedge clk) disable iff (reset)
        cla_valid |-> ($past(state) == LOOKUP_CMP)
    );

endmodule

/* logic/classifier_reg.sv */
// classifier register port
// holds the aging time, counts hits and misses with saturation and
// returns register contents one cycle after a read

module classifier_reg
    import classifier_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,

    input  logic                      reg_wr,
    input  logic                      reg_rd,
    input  reg_addr_e                 reg_addr,
    input  logic [REG_DATA_NBITS-1:0] reg_wdata,
    output logic                      reg_rvalid,
    output logic [REG_DATA_NBITS-1:0] reg_rdata,

    input  logic                      hit_inc,
    input  logic                      miss_inc,
    input  logic [TIME_NBITS-1:0]     current_time,
    output logic [TIME_NBITS-1:0]     aging_time
);

    logic [REG_DATA_NBITS-1:0] hits;
    logic [REG_DATA_NBITS-1:0] misses;

    // only the aging register is writable
    always_ff @(posedge clk) begin
        if (reset) begin
            aging_time <= AGING_RESET;
            hits       <= '0;
            misses     <= '0;
            reg_rvalid <= 1'b0;
        end else begin
            reg_rvalid <= reg_rd;
            if (reg_wr && reg_addr == REG_AGING) begin
                aging_time <= reg_wdata;
            end
            // counters stick at all ones
            if (hit_inc && hits != '1) begin
                hits <= hits + 1'b1;
            end
            if (miss_inc && misses != '1) begin
                misses <= misses + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reg_rd) begin
            case (reg_addr)
                REG_AGING:  reg_rdata <= aging_time;
                REG_HITS:   reg_rdata <= hits;
                REG_MISSES: reg_rdata <= misses;
                REG_TIME:   reg_rdata <= current_time;
                default:    reg_rdata <= '0;
            endcase
        end
    end

    a_no_rd_wr: assert property (
        @(posedge clk) disable iff (reset)
        !(reg_rd && reg_wr)
    );

endmodule

/* logic/classifier.sv */
// flow classifier top level
// connects the time base, the two-bank flow table, the lookup/learn
// sequencer and the register port

module classifier
    import classifier_pkg::*;
#(
    parameter int DEPTH_NBITS = 4,
    parameter int TICK_CYCLES = 4
) (
    input  logic                      clk,
    input  logic                      reset,

    input  logic                      par_valid,
    input  lookup_req_t               par_req,
    input  logic                      learn_valid,
    input  learn_req_t                learn_req,

    output logic                      cla_valid,
    output lookup_res_t               cla_res,

    input  logic                      reg_wr,
    input  logic                      reg_rd,
    input  reg_addr_e                 reg_addr,
    input  logic [REG_DATA_NBITS-1:0] reg_wdata,
    output logic                      reg_rvalid,
    output logic [REG_DATA_NBITS-1:0] reg_rdata
);

    logic [TIME_NBITS-1:0]  current_time;
    logic [TIME_NBITS-1:0]  aging_time;
    logic                   hit_inc;
    logic                   miss_inc;

    logic                   rd;
    logic [DEPTH_NBITS-1:0] idx0;
    logic [DEPTH_NBITS-1:0] idx1;
    flow_entry_t            entry0;
    flow_entry_t            entry1;
    logic                   wr;
    logic                   wr_bank;
    logic [DEPTH_NBITS-1:0] wr_idx;
    flow_entry_t            wr_entry;

    time_counter #(
        .TICK_CYCLES(TICK_CYCLES)
    ) u_time_counter (
        .clk         (clk),
        .reset       (reset),
        .current_time(current_time)
    );

    flow_table #(
        .DEPTH_NBITS(DEPTH_NBITS)
    ) u_flow_table (
        .clk     (clk),
        .reset   (reset),
        .rd      (rd),
        .idx0    (idx0),
        .idx1    (idx1),
        .entry0  (entry0),
        .entry1  (entry1),
        .wr      (wr),
        .wr_bank (wr_bank),
        .wr_idx  (wr_idx),
        .wr_entry(wr_entry)
    );

    lookup_fsm #(
        .DEPTH_NBITS(DEPTH_NBITS)
    ) u_lookup_fsm (
        .clk         (clk),
        .reset       (reset),
        .par_valid   (par_valid),
        .par_req     (par_req),
        .learn_valid (learn_valid),
        .learn_req   (learn_req),
        .current_time(current_time),
        .aging_time  (aging_time),
        .rd          (rd),
        .idx0        (idx0),
        .idx1        (idx1),
        .entry0      (entry0),
        .entry1      (entry1),
        .wr          (wr),
        .wr_bank     (wr_bank),
        .wr_idx      (wr_idx),
        .wr_entry    (wr_entry),
        .cla_valid   (cla_valid),
        .cla_res     (cla_res),
        .hit_inc     (hit_inc),
        .miss_inc    (miss_inc)
    );

    classifier_reg u_classifier_reg (
        .clk         (clk),
        .reset       (reset),
        .reg_wr      (reg_wr),
        .reg_rd      (reg_rd),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .reg_rvalid  (reg_rvalid),
        .reg_rdata   (reg_rdata),
        .hit_inc     (hit_inc),
        .miss_inc    (miss_inc),
        .current_time(current_time),
        .aging_time  (aging_time)
    );

endmodule

/* bench/classifier_tb.sv */
// flow classifier testbench
// learns and looks up random flows against a table model kept in
// the bench, exercises aging and the register port, and checks the
// DUT responses with concurrent assertions

module classifier_tb
    import classifier_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int DEPTH_NBITS = 4;
    localparam int TICK_CYCLES = 4;
    localparam int DEPTH       = 1 << DEPTH_NBITS;
    localparam int MAX_CYCLES  = 4000;

    logic                      clk;
    logic                      reset;
    logic                      par_valid;
    lookup_req_t               par_req;
    logic                      learn_valid;
    learn_req_t                learn_req;
    logic                      cla_valid;
    lookup_res_t               cla_res;
    logic                      reg_wr;
    logic                      reg_rd;
    reg_addr_e                 reg_addr;
    logic [REG_DATA_NBITS-1:0] reg_wdata;
    logic                      reg_rvalid;
    logic [REG_DATA_NBITS-1:0] reg_rdata;

    // bench model of the table, the counters and the time base
    flow_entry_t               model [2][DEPTH];
    int unsigned               edges;
    int unsigned               cycles;
    logic [TIME_NBITS-1:0]     model_aging;
    logic [15:0]               model_hits;
    logic [15:0]               model_misses;
    lookup_res_t               exp_res;
    logic [REG_DATA_NBITS-1:0] exp_rdata;
    int                        errors;
    int                        test_errors;
    int                        tests_run;
    int                        tests_failed;

    classifier #(
        .DEPTH_NBITS(DEPTH_NBITS),
        .TICK_CYCLES(TICK_CYCLES)
    ) uut (
        .clk        (clk),
        .reset      (reset),
        .par_valid  (par_valid),
        .par_req    (par_req),
        .learn_valid(learn_valid),
        .learn_req  (learn_req),
        .cla_valid  (cla_valid),
        .cla_res    (cla_res),
        .reg_wr     (reg_wr),
        .reg_rd     (reg_rd),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rvalid (reg_rvalid),
        .reg_rdata  (reg_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // edges counts the clock edges since reset release
    // and the DUT time is edges / TICK_CYCLES
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (reset) begin
            edges <= 0;
        end else begin
            edges <= edges + 1;
        end
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    always @(posedge clk) begin
        if (reg_rd) begin
            case (reg_addr)
                REG_AGING:  exp_rdata <= model_aging;
                REG_HITS:   exp_rdata <= model_hits;
                REG_MISSES: exp_rdata <= model_misses;
                default:    exp_rdata <= REG_DATA_NBITS'(edges / TICK_CYCLES);
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic record_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        errors++;
        $display("Fail %s expected %h got %h", name, exp, act);
    endtask

    task automatic report_missing(input string what);
        errors++;
        $display("error: %s", what);
    endtask

    a_result_pulse: assert property (@(posedge clk) disable iff (reset)
        par_valid |-> ##3 cla_valid)
        else report_missing("no lookup result 3 cycles after the request");

    a_no_stray_result: assert property (@(posedge clk) disable iff (reset)
        cla_valid |-> $past(par_valid, 3))
        else report_missing("a lookup result appeared without a request");

    a_result_value: assert property (@(posedge clk) disable iff (reset)
        $past(par_valid, 3) |-> cla_res == exp_res)
        else record_mismatch("cla_res", $sampled(exp_res), $sampled(cla_res));

    a_read_pulse: assert property (@(posedge clk) disable iff (reset)
        reg_rd |=> reg_rvalid)
        else report_missing("read data valid did not follow a register read");

    a_no_stray_read: assert property (@(posedge clk) disable iff (reset)
        reg_rvalid |-> $past(reg_rd))
        else report_missing("read data valid without a register read");

    a_read_value: assert property (@(posedge clk) disable iff (reset)
        reg_rvalid |-> reg_rdata == exp_rdata)
        else record_mismatch("reg_rdata", $sampled(exp_rdata), $sampled(reg_rdata));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // table model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [7:0] rotate(input logic [7:0] b, input int n);
        return (b << n) | (b >> (8 - n));
    endfunction

    function automatic logic [DEPTH_NBITS-1:0] hash0(input logic [31:0] k);
        return DEPTH_NBITS'(k[7:0] ^ k[15:8] ^ k[23:16] ^ k[31:24]);
    endfunction

    function automatic logic [DEPTH_NBITS-1:0] hash1(input logic [31:0] k);
        return DEPTH_NBITS'(rotate(k[7:0], 0) ^ rotate(k[15:8], 1)
                            ^ rotate(k[23:16], 2) ^ rotate(k[31:24], 3));
    endfunction

    // time seen in the compare or write cycle of a strobe driven now
    function automatic logic [TIME_NBITS-1:0] op_time();
        return TIME_NBITS'((edges + 3) / TICK_CYCLES);
    endfunction

    function automatic bit live(input int b, input int i, input logic [TIME_NBITS-1:0] t);
        return model[b][i].valid && (t < model[b][i].etime);
    endfunction

    task automatic lookup(input logic [31:0] key);
        logic [TIME_NBITS-1:0] t;
        lookup_res_t           res;
        @(posedge clk);
        t       = op_time();
        res.tag = 8'($urandom());
        res.hit = 1'b0;
        res.fid = '0;
        if (live(0, hash0(key), t) && model[0][hash0(key)].key == key) begin
            res.hit = 1'b1;
            res.fid = model[0][hash0(key)].fid;
        end else if (live(1, hash1(key), t) && model[1][hash1(key)].key == key) begin
            res.hit = 1'b1;
            res.fid = model[1][hash1(key)].fid;
        end
        if (res.hit) begin
            model_hits = model_hits + 1'b1;
        end else begin
            model_misses = model_misses + 1'b1;
        end
        par_valid   <= 1'b1;
        par_req.key <= key;
        par_req.tag <= res.tag;
        exp_res     <= res;
        @(posedge clk);
        par_valid <= 1'b0;
        for (int n = 0; n < 8 && !cla_valid; n++) begin
            @(posedge clk);
        end
    endtask

    task automatic learn(input logic [31:0] key, input logic [7:0] fid);
        logic [TIME_NBITS-1:0] t;
        flow_entry_t           e;
        @(posedge clk);
        t       = op_time();
        e.valid = 1'b1;
        e.key   = key;
        e.fid   = fid;
        e.etime = t + model_aging;
        if (live(0, hash0(key), t) && model[0][hash0(key)].key != key) begin
            model[1][hash1(key)] = e;
        end else begin
            model[0][hash0(key)] = e;
        end
        learn_valid   <= 1'b1;
        learn_req.key <= key;
        learn_req.fid <= fid;
        @(posedge clk);
        learn_valid <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task automatic reg_write(input reg_addr_e addr, input logic [15:0] data);
        @(posedge clk);
        reg_wr    <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        if (addr == REG_AGING) begin
            model_aging = data;
        end
        @(posedge clk);
        reg_wr <= 1'b0;
    endtask

    task automatic reg_read(input reg_addr_e addr, output logic [15:0] data);
        @(posedge clk);
        reg_rd   <= 1'b1;
        reg_addr <= addr;
        @(posedge clk);
        reg_rd <= 1'b0;
        @(posedge clk);
        data = reg_rdata;
    endtask

    // a key whose bank 0 slot is free, or one sharing hash0 with prev
    function automatic logic [31:0] pick_key(input bit same_idx, input logic [31:0] prev);
        logic [31:0] k;
        for (int n = 0; n < 1000; n++) begin
            k = $urandom();
            if (same_idx ? (hash0(k) == hash0(prev) && k != prev)
                         : !live(0, hash0(k), op_time())) begin
                return k;
            end
        end
        return k;
    endfunction

    task automatic end_test(input string name);
        @(posedge clk);
        tests_run++;
        if (errors == test_errors) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name,
                     errors - test_errors);
        end
        test_errors = errors;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        logic [31:0] keys [8];
        logic [7:0]  fids [8];
        logic [31:0] k1;
        logic [31:0] k2;
        logic [15:0] data;
        logic [15:0] t0;
        logic [15:0] t1;
        void'($urandom(23));
        reset        = 1'b1;
        par_valid    = 1'b0;
        par_req      = '0;
        learn_valid  = 1'b0;
        learn_req    = '0;
        reg_wr       = 1'b0;
        reg_rd       = 1'b0;
        reg_addr     = REG_AGING;
        reg_wdata    = '0;
        cycles       = 0;
        edges        = 0;
        model_aging  = AGING_RESET;
        model_hits   = '0;
        model_misses = '0;
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int b = 0; b < 2; b++) begin
            for (int i = 0; i < DEPTH; i++) begin
                model[b][i] = '0;
            end
        end
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        reg_read(REG_AGING, data);
        reg_read(REG_HITS, data);
        reg_read(REG_MISSES, data);
        lookup($urandom());
        end_test("reset state");

        // each key gets a free bank 0 slot so that every lookup hits
        for (int i = 0; i < 8; i++) begin
            keys[i] = pick_key(1'b0, '0);
            fids[i] = 8'($urandom());
            learn(keys[i], fids[i]);
        end
        for (int i = 0; i < 8; i++) begin
            lookup(keys[i]);
        end
        end_test("learn and look up eight flows");

        // the second key collides in bank 0 and falls back to bank 1
        k1 = pick_key(1'b0, '0);
        k2 = pick_key(1'b1, k1);
        learn(k1, 8'($urandom()));
        learn(k2, 8'($urandom()));
        lookup(k1);
        lookup(k2);
        end_test("hash0 collision");

        reg_write(REG_AGING, 16'd5);
        k1 = pick_key(1'b0, '0);
        learn(k1, 8'($urandom()));
        lookup(k1);
        t0 = model[0][hash0(k1)].etime;
        do begin
            reg_read(REG_TIME, data);
        end while (data < t0 + 16'd1);
        lookup(k1);
        learn(k1, 8'($urandom()));
        lookup(k1);
        end_test("aging and relearn");

        reg_read(REG_HITS, data);
        reg_read(REG_MISSES, data);
        reg_write(REG_HITS, 16'h5a5a);
        reg_read(REG_HITS, data);
        end_test("hit and miss counters");

        reg_read(REG_TIME, t0);
        repeat (37) @(posedge clk);
        reg_read(REG_TIME, t1);
        a_time_step: assert (t1 - t0 == 16'd10)
            else record_mismatch("REG_TIME delta", 64'd10, 64'(t1 - t0));
        end_test("time base");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* classifier.f */
logic/classifier_pkg.sv
logic/time_counter.sv
logic/flow_hash.sv
logic/flow_table.sv
logic/lookup_fsm.sv
logic/classifier_reg.sv
logic/classifier.sv
bench/classifier_tb.sv
